/* source/mips_pkg.sv */
package mips_pkg;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'b000000; // Special, funct selects op
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;
	localparam logic [5:0] op_beq   = 6'b000100;
	localparam logic [5:0] op_addi  = 6'b001000;
	localparam logic [5:0] op_j     = 6'b000010;

	// R-type funct codes, instr[5:0]
	localparam logic [5:0] funct_add = 6'b100000;
	localparam logic [5:0] funct_sub = 6'b100010;
	localparam logic [5:0] funct_and = 6'b100100;
	localparam logic [5:0] funct_or  = 6'b100101;
	localparam logic [5:0] funct_slt = 6'b101010;

	// ALU control, classic 3-bit encoding
	// Bit 2 inverts b and feeds carry in
	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_sub = 3'b110,
		alu_slt = 3'b111  // Signed compare, 1 or 0
	} alu_op_t;

	// Boot ROM base in kseg1, PC after reset
	localparam logic [31:0] reset_vector = 32'hBFC00000;

	// Return value register, tapped for observation
	localparam logic [4:0] reg_v0 = 5'd2;

endpackage

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
	input  mips_pkg::alu_op_t op,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	output logic [31:0]       result,
	output logic              zero
);
	import mips_pkg::*;

	logic [31:0] sum;
	logic [31:0] diff;
	logic        less;

	assign sum  = a + b;
	assign diff = a - b; // Two's complement, wraps on overflow

	// Signed compare, overflow-safe
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_add: result = sum;
			alu_sub: result = diff;
			alu_slt: result = {31'd0, less};
			default: result = 32'd0; // Encodings 011..101 unused
		endcase
	end

	// BEQ looks at this after a subtract
	assign zero = (result == 32'd0);

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic        clk,
	input  logic        reset,
	input  logic        write_enable,
	input  logic [4:0]  read_addr_a,
	input  logic [4:0]  read_addr_b,
	input  logic [4:0]  write_addr,
	input  logic [31:0] write_data,
	output logic [31:0] read_data_a,
	output logic [31:0] read_data_b,
	output logic [31:0] v0
);
	import mips_pkg::*;

	logic [31:0] regs [32];

	// Write on edge, $zero never written
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (write_enable && (write_addr != 5'd0)) begin
			regs[write_addr] <= write_data;
		end
	end

	// Combinational reads, register 0 reads as zero
	assign read_data_a = (read_addr_a == 5'd0) ? 32'd0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == 5'd0) ? 32'd0 : regs[read_addr_b];

	assign v0 = regs[reg_v0]; // Observation tap

endmodule

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  logic [31:0]       instr,
	output logic              reg_write,
	output logic              reg_dst,
	output logic              alu_src,
	output logic              branch,
	output logic              mem_write,
	output logic              mem_to_reg,
	output logic              jump,
	output mips_pkg::alu_op_t alu_op
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		// Default is a no-op, nothing written
		reg_write  = 1'b0;
		reg_dst    = 1'b0;
		alu_src    = 1'b0;
		branch     = 1'b0;
		mem_write  = 1'b0;
		mem_to_reg = 1'b0;
		jump       = 1'b0;
		alu_op     = alu_add;

		case (opcode)
			op_rtype: begin
				reg_dst = 1'b1; // Destination is rd
				// ALU op straight from funct
				case (funct)
					funct_add: begin
						reg_write = 1'b1;
						alu_op    = alu_add;
					end
					funct_sub: begin
						reg_write = 1'b1;
						alu_op    = alu_sub;
					end
					funct_and: begin
						reg_write = 1'b1;
						alu_op    = alu_and;
					end
					funct_or: begin
						reg_write = 1'b1;
						alu_op    = alu_or;
					end
					funct_slt: begin
						reg_write = 1'b1;
						alu_op    = alu_slt;
					end
					default: reg_write = 1'b0; // Unknown funct, no-op
				endcase
			end
			op_lw: begin
				reg_write  = 1'b1;
				alu_src    = 1'b1; // base + offset
				mem_to_reg = 1'b1; // Write back load data
			end
			op_sw: begin
				alu_src   = 1'b1;
				mem_write = 1'b1;
			end
			op_beq: begin
				branch = 1'b1;
				alu_op = alu_sub; // Zero flag means equal
			end
			op_addi: begin
				reg_write = 1'b1;
				alu_src   = 1'b1; // Sign-extended immediate
			end
			op_j: jump = 1'b1;
			default: jump = 1'b0; // Undefined opcode, falls through to PC+4
		endcase
	end

endmodule

/* source/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input  logic              clk,
	input  logic              reset,
	input  logic              clk_enable,
	input  logic [31:0]       instr,
	input  logic              reg_write,
	input  logic              reg_dst,
	input  logic              alu_src,
	input  logic              branch,
	input  logic              mem_write,
	input  logic              mem_to_reg,
	input  logic              jump,
	input  mips_pkg::alu_op_t alu_op,
	input  logic [31:0]       data_readdata,
	output logic [31:0]       pc,
	output logic [31:0]       alu_result,
	output logic [31:0]       write_data,
	output logic              data_write,
	output logic              data_read,
	output logic              active,
	output logic [31:0]       register_v0
);
	import mips_pkg::*;

	// Instruction fields
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm;
	logic [25:0] jump_index;

	// Next-PC path
	logic [31:0] pc_plus4;
	logic [31:0] imm_ext;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] pc_next;
	logic        zero;
	logic        take_branch;
	logic        halt;

	// Operands and write-back
	logic [4:0]  write_reg;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [31:0] rt_value;
	logic [31:0] wb_data;

	// Gating
	logic        run;
	logic        mem_enable;
	logic        rf_write;

	assign rs         = instr[25:21];
	assign rt         = instr[20:16];
	assign rd         = instr[15:11];
	assign imm        = instr[15:0];
	assign jump_index = instr[25:0];

	// Retire only on enabled edges while not halted
	assign run = clk_enable & active;

	// Memory strobes stay off while reset is asserted
	assign mem_enable = run & ~reset;

	assign rf_write   = reg_write & run;
	assign data_write = mem_write & mem_enable;
	assign data_read  = mem_to_reg & mem_enable; // Only LW sets mem_to_reg

	assign imm_ext = {{16{imm[15]}}, imm}; // Sign extend

	assign write_reg = reg_dst ? rd : rt; // rd for R-type, rt otherwise

	assign src_b = alu_src ? imm_ext : rt_value;

	assign write_data = rt_value; // SW stores rt

	assign wb_data = mem_to_reg ? data_readdata : alu_result;

	reg_file u_reg_file (
		.clk          (clk),
		.reset        (reset),
		.write_enable (rf_write),
		.read_addr_a  (rs),
		.read_addr_b  (rt),
		.write_addr   (write_reg),
		.write_data   (wb_data),
		.read_data_a  (src_a),
		.read_data_b  (rt_value),
		.v0           (register_v0)
	);

	alu u_alu (
		.op     (alu_op),
		.a      (src_a),
		.b      (src_b),
		.result (alu_result),
		.zero   (zero)
	);

	assign pc_plus4 = pc + 32'd4;

	// Word offset relative to the following instruction
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};

	// Region bits kept from PC+4
	assign jump_target = {pc_plus4[31:28], jump_index, 2'b00};

	assign take_branch = branch & zero; // BEQ taken when rs == rt

	always_comb begin
		if (jump) begin
			pc_next = jump_target;
		end else if (take_branch) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc_plus4; // Also for undecoded opcodes
		end
	end

	// Self-jump means the program has finished
	assign halt = jump & (jump_target == pc);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= reset_vector;
		end else if (run) begin
			pc <= pc_next; // Halt jump lands on itself
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b1;
		end else if (run && halt) begin
			active <= 1'b0; // Sticky until next reset
		end
	end

endmodule

/* source/mips_cpu_harvard.sv */
`timescale 1ns/1ps

module mips_cpu_harvard (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	output logic        active,
	output logic [31:0] register_v0,

	// Instruction port, combinational read
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,

	// Data port, combinational read, write on edge
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);
	import mips_pkg::*;

	// Control from decoder to datapath
	logic    reg_write;
	logic    reg_dst;
	logic    alu_src;
	logic    branch;
	logic    mem_write;
	logic    mem_to_reg;
	logic    jump;
	alu_op_t alu_op;

	instr_decoder u_instr_decoder (
		.instr      (instr_readdata), // Only opcode and funct are decoded
		.reg_write  (reg_write),
		.reg_dst    (reg_dst),
		.alu_src    (alu_src),
		.branch     (branch),
		.mem_write  (mem_write),
		.mem_to_reg (mem_to_reg),
		.jump       (jump),
		.alu_op     (alu_op)
	);

	datapath u_datapath (
		.clk           (clk),
		.reset         (reset),
		.clk_enable    (clk_enable),
		.instr         (instr_readdata),
		.reg_write     (reg_write),
		.reg_dst       (reg_dst),
		.alu_src       (alu_src),
		.branch        (branch),
		.mem_write     (mem_write),
		.mem_to_reg    (mem_to_reg),
		.jump          (jump),
		.alu_op        (alu_op),
		.data_readdata (data_readdata),
		.pc            (instr_address),
		.alu_result    (data_address),   // Effective address for LW/SW
		.write_data    (data_writedata), // rt value for SW
		.data_write    (data_write),
		.data_read     (data_read),
		.active        (active),
		.register_v0   (register_v0)
	);

endmodule

/* dv/mips_memory_model.sv */
`timescale 1ns/1ps

module mips_memory_model (
	input  logic        clk,
	input  logic [31:0] instr_address,
	output logic [31:0] instr_readdata,
	input  logic [31:0] data_address,
	input  logic        data_write,
	input  logic        data_read,
	input  logic [31:0] data_writedata,
	output logic [31:0] data_readdata
);
	import mips_pkg::*;

	logic [31:0] rom [256]; // Word 0 sits at reset_vector
	logic [31:0] ram [256]; // Byte addresses 0..0x3FC
	logic [31:0] rom_offset;

	// Log of every data write
	logic [31:0] log_addr [64];
	logic [31:0] log_data [64];
	int          write_count;

	assign rom_offset = instr_address - reset_vector;

	// Outside the ROM reads as all zero, a no-op
	assign instr_readdata = (rom_offset < 32'd1024) ? rom[rom_offset[9:2]] : 32'd0;
	assign data_readdata  = data_read ? ram[data_address[9:2]] : 32'd0;

	always @(posedge clk) begin
		if (data_write) begin
			ram[data_address[9:2]] <= data_writedata;
			if (write_count < 64) begin
				log_addr[write_count] <= data_address;
				log_data[write_count] <= data_writedata;
			end
			write_count <= write_count + 1;
		end
	end

	task automatic clear_rom();
		for (int i = 0; i < 256; i++) begin
			rom[i] = 32'd0;
		end
	endtask

	// Each word holds its own byte address
	task automatic fill_ram();
		for (int i = 0; i < 256; i++) begin
			ram[i] = 32'hDA7A0000 | 32'(i << 2);
		end
	endtask

	task automatic clear_log();
		write_count = 0;
	endtask

	task automatic load_instr(input int index, input logic [31:0] word);
		rom[index] = word;
	endtask

	task automatic load_data(input logic [31:0] addr, input logic [31:0] word);
		ram[addr[9:2]] = word;
	endtask

	initial begin
		clear_rom();
		fill_ram();
		clear_log();
	end

endmodule

/* dv/tb_mips_cpu_harvard.sv */
`timescale 1ns/1ps

module tb_mips_cpu_harvard;
	import mips_pkg::*;

	localparam int run_budget = 32;     // Cycles allowed per program
	localparam int run_count  = 12;     // Program runs over all tests
	localparam int run_cycles = run_budget + 10; // Plus reset and post-halt cycles

	logic        clk = 1'b0;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;

	logic [31:0] rand_state = 32'h57a24c15;
	logic [31:0] pc_trace [64]; // PCs of retired instructions
	int          trace_len;
	int          prog_len;
	logic        halted;
	logic        read_seen;
	int          error_count = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	always #50 clk = ~clk;

	mips_cpu_harvard u_mips_cpu_harvard (
		.clk            (clk),
		.reset          (reset),
		.clk_enable     (clk_enable),
		.active         (active),
		.register_v0    (register_v0),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	mips_memory_model u_mem (
		.clk            (clk),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223; // LCG step
		return rand_state;
	endfunction

	function automatic logic [31:0] encode_r(input logic [5:0] funct, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {op_rtype, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encode_j(input logic [31:0] target);
		return {op_j, target[27:2]};
	endfunction

	function automatic logic [31:0] instr_addr(input int index);
		return reset_vector + 32'(index * 4);
	endfunction

	// Reference results for the R-type ops
	function automatic logic [31:0] r_type_result(input logic [5:0] funct, input logic [31:0] a,
			input logic [31:0] b);
		case (funct)
			funct_add: return a + b;
			funct_sub: return a - b;
			funct_and: return a & b;
			funct_or:  return a | b;
			funct_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default:   return 32'd0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %h, got %h", name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		error_count++;
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic new_program();
		u_mem.clear_rom();
		u_mem.fill_ram();
		u_mem.clear_log();
		prog_len = 0;
	endtask

	task automatic put_instr(input logic [31:0] word);
		u_mem.load_instr(prog_len, word);
		prog_len++;
	endtask

	task automatic put_halt();
		put_instr(encode_j(instr_addr(prog_len))); // Jump onto itself
	endtask

	task automatic reset_core();
		@(posedge clk);
		reset      <= 1'b1;
		clk_enable <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	// Runs until active falls; an optional stall window drops clk_enable
	task automatic run_program(input int stall_start, input int stall_len);
		int          cycle;
		logic [31:0] prev_pc;
		logic        prev_stalled;
		cycle        = 0;
		trace_len    = 0;
		read_seen    = 1'b0;
		halted       = 1'b0;
		prev_pc      = 32'd0;
		prev_stalled = 1'b0;
		while (!halted && cycle < run_budget) begin
			@(negedge clk); // Outputs settled here
			if (!active) begin
				halted = 1'b1;
			end else begin
				if (prev_stalled) check_value("instr_address", prev_pc, instr_address);
				if (!clk_enable) begin
					check_value("data_write", 32'd0, {31'd0, data_write});
				end else begin
					pc_trace[trace_len] = instr_address;
					trace_len++;
					if (data_read) read_seen = 1'b1;
				end
				prev_pc      = instr_address;
				prev_stalled = !clk_enable;
				@(posedge clk);
				clk_enable <= !(cycle >= stall_start && cycle < stall_start + stall_len);
				cycle++;
			end
		end
		if (!halted) report_error($sformatf("core did not halt within %0d cycles", run_budget));
	endtask

	task automatic arithmetic_ops();
		logic [5:0]  funct;
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		for (int k = 0; k < 5; k++) begin
			case (k)
				0: funct = funct_add;
				1: funct = funct_sub;
				2: funct = funct_and;
				3: funct = funct_or;
				default: funct = funct_slt;
			endcase
			r = next_random();
			a = {{16{r[15]}}, r[15:0]}; // Same sign extension as ADDI
			b = {{16{r[31]}}, r[31:16]};
			new_program();
			put_instr(encode_i(op_addi, 5'd8, 5'd0, a[15:0]));
			put_instr(encode_i(op_addi, 5'd9, 5'd0, b[15:0]));
			put_instr(encode_r(funct, 5'd2, 5'd8, 5'd9));
			put_halt();
			reset_core();
			run_program(0, 0);
			check_value("register_v0", r_type_result(funct, a, b), register_v0);
		end
		finish_test("arithmetic");
	endtask

	task automatic load_store();
		logic [31:0] base;
		logic [31:0] off;
		logic [31:0] value;
		base  = next_random() & 32'h1FC;
		off   = 32'd4 + (next_random() & 32'hFC); // Never the base word
		value = next_random();
		new_program();
		u_mem.load_data(base, value);
		put_instr(encode_i(op_addi, 5'd8, 5'd0, base[15:0]));
		put_instr(encode_i(op_lw, 5'd9, 5'd8, 16'd0));
		put_instr(encode_i(op_sw, 5'd9, 5'd8, off[15:0]));
		put_instr(encode_i(op_lw, 5'd2, 5'd8, off[15:0]));
		put_halt();
		reset_core();
		run_program(0, 0);
		check_value("write_count", 32'd1, u_mem.write_count);
		check_value("data_address", base + off, u_mem.log_addr[0]);
		check_value("data_writedata", value, u_mem.log_data[0]);
		if (!read_seen) report_error("data_read never went high during the loads");
		check_value("register_v0", value, register_v0);
		finish_test("load_store");
	endtask

	task automatic branch_paths();
		logic [31:0] expect_pc [6];
		new_program();
		put_instr(encode_i(op_addi, 5'd8, 5'd0, 16'd5));
		put_instr(encode_i(op_addi, 5'd9, 5'd0, 16'd5));
		put_instr(encode_i(op_beq, 5'd9, 5'd8, 16'd1));  // Taken, skips next
		put_instr(encode_i(op_addi, 5'd2, 5'd0, 16'h111));
		put_instr(encode_i(op_beq, 5'd0, 5'd8, 16'd1));  // 5 != 0, falls through
		put_instr(encode_i(op_addi, 5'd2, 5'd2, 16'h22));
		put_halt();
		expect_pc[0] = instr_addr(0);
		expect_pc[1] = expect_pc[0] + 32'd4;
		expect_pc[2] = expect_pc[1] + 32'd4;
		expect_pc[3] = expect_pc[2] + 32'd4 + (32'd1 << 2); // PC+4 plus offset words
		expect_pc[4] = expect_pc[3] + 32'd4;
		expect_pc[5] = expect_pc[4] + 32'd4;
		reset_core();
		run_program(0, 0);
		check_value("trace_len", 32'd6, trace_len);
		for (int k = 0; k < 6 && k < trace_len; k++) begin
			check_value($sformatf("instr_address[%0d]", k), expect_pc[k], pc_trace[k]);
		end
		check_value("register_v0", 32'h22, register_v0);
		finish_test("branches");
	endtask

	task automatic jump_halt();
		new_program();
		put_instr(encode_i(op_addi, 5'd2, 5'd0, 16'd1));
		put_instr(encode_j(instr_addr(3)));             // Forward over the next one
		put_instr(encode_i(op_addi, 5'd2, 5'd0, 16'h7F));
		put_instr(encode_i(op_sw, 5'd2, 5'd0, 16'h10));
		put_halt();
		reset_core();
		run_program(0, 0);
		check_value("register_v0", 32'd1, register_v0);
		repeat (5) begin
			@(negedge clk);
			check_value("instr_address", instr_addr(4), instr_address);
			check_value("active", 32'd0, {31'd0, active});
		end
		check_value("write_count", 32'd1, u_mem.write_count); // Only the SW before halt
		check_value("data_address", 32'h10, u_mem.log_addr[0]);
		finish_test("jump_halt");
	endtask

	task automatic stall_hold();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] clean_v0;
		r = next_random();
		a = {{16{r[15]}}, r[15:0]};
		b = {{16{r[31]}}, r[31:16]};
		new_program();
		put_instr(encode_i(op_addi, 5'd8, 5'd0, a[15:0]));
		put_instr(encode_i(op_addi, 5'd9, 5'd0, b[15:0]));
		put_instr(encode_i(op_sw, 5'd8, 5'd0, 16'h20));
		put_instr(encode_r(funct_add, 5'd2, 5'd8, 5'd9));
		put_instr(encode_i(op_addi, 5'd2, 5'd2, 16'd3));
		put_halt();
		reset_core();
		run_program(0, 0);
		clean_v0 = register_v0;
		check_value("register_v0", a + b + 32'd3, clean_v0);
		u_mem.clear_log();
		reset_core();
		r = next_random();
		run_program(1, 2 + int'(r[9:8])); // Stall holds the SW, length 2..5
		check_value("register_v0", clean_v0, register_v0);
		check_value("write_count", 32'd1, u_mem.write_count);
		finish_test("stall");
	endtask

	task automatic zero_reg_and_undefined();
		logic [31:0] r;
		new_program();
		put_instr(encode_i(op_addi, 5'd2, 5'd0, 16'h1234));
		put_instr(encode_i(op_addi, 5'd0, 5'd0, 16'h55)); // Write to $zero is dropped
		put_instr(encode_r(funct_add, 5'd2, 5'd0, 5'd0));
		put_halt();
		reset_core();
		run_program(0, 0);
		check_value("register_v0", 32'd0, register_v0);
		r = next_random();
		new_program();
		put_instr(encode_i(op_addi, 5'd2, 5'd0, 16'h66));
		put_instr({6'b111111, r[25:21], 5'd2, 5'd2, r[10:0]}); // Unknown opcode, rt and rd on v0
		put_halt();
		reset_core();
		run_program(0, 0);
		check_value("register_v0", 32'h66, register_v0);
		check_value("write_count", 32'd0, u_mem.write_count);
		check_value("trace_len", 32'd3, trace_len);
		check_value("instr_address[2]", instr_addr(2), pc_trace[2]);
		finish_test("zero_and_undefined");
	endtask

	// Whole run bounded by the per-program budget
	initial begin
		#(run_count * run_cycles * 100 + 2000);
		$display("run timed out after %0d programs' worth of cycles", run_count);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		reset      = 1'b1;
		clk_enable = 1'b0;
		arithmetic_ops();
		load_store();
		branch_paths();
		jump_halt();
		stall_hold();
		zero_reg_and_undefined();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* mips_cpu_harvard.f */
source/mips_pkg.sv
source/alu.sv
source/reg_file.sv
source/instr_decoder.sv
source/datapath.sv
source/mips_cpu_harvard.sv
dv/mips_memory_model.sv
dv/tb_mips_cpu_harvard.sv
